/* files.f */
logic/cpu_types_pkg.sv
logic/mem_pass_pkg.sv
logic/addr_trans.sv
logic/memory1_stage.sv
logic/dcache_array.sv
logic/memory2_stage.sv
logic/mem_pipe_top.sv
verification/mem_pipe_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mem_pipe_tb -f files.f -o mem_pipe_sim

out=$(./obj_dir/mem_pipe_sim)
echo "$out"

echo "$out" | grep -q "Verification passed"

/* verification/mem_pipe_tb.sv */
`timescale 1ns/1ps

module mem_pipe_tb
    import cpu_types_pkg::*;
    import mem_pass_pkg::*;
;

    localparam int T1_OPS = 40;
    localparam int T2_OPS = 16;
    localparam int T3_OPS = 16;
    localparam int T4_OPS = 8;
    localparam int T5_OPS = 10;
    localparam int TOTAL_OPS = DCACHE_WORDS + 2 * (T1_OPS + T2_OPS + T3_OPS + T4_OPS + T5_OPS) + 8;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 6;

    // One expected result from memory2
    typedef struct packed {
        logic     is_excp;
        reg_idx_t rd;
        u32_t     data;
        ecode_t   ecode;
        u32_t     badv;
        u32_t     pc;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  flush_i;
    execute_memory1_pass_t pass_i;
    csr_t                  csr_i;
    logic                  stall_o;
    forward_req_t          fwd_o;
    wb_t                   wb_o;
    excp_pass_t            excp_o;

    u32_t    model [DCACHE_WORDS];
    expect_t exp_q [$];
    logic [31:0] lfsr;
    u32_t    pc_cnt;
    int      err_cnt;
    int      stall_cnt;

    mem_pipe_top u_mem_pipe_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .pass_i  (pass_i),
        .csr_i   (csr_i),
        .stall_o (stall_o),
        .fwd_o   (fwd_o),
        .wb_o    (wb_o),
        .excp_o  (excp_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic u32_t rand_bits(input int n);
        u32_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic execute_memory1_pass_t make_op(input u32_t addr, input u32_t data,
                                                      input logic is_mem, input logic st,
                                                      input logic sgn, input byte_type_t bt,
                                                      input reg_idx_t rd);
        execute_memory1_pass_t p;
        p = '0;
        p.valid     = 1'b1;
        p.pc        = pc_cnt;
        p.ex_out    = addr;
        p.rkd_data  = data;
        p.is_mem    = is_mem;
        p.is_store  = st;
        p.is_signed = sgn;
        p.byte_type = bt;
        p.is_wr_rd  = !st;
        p.rd        = rd;
        pc_cnt = pc_cnt + 32'd4;
        return p;
    endfunction

    function automatic u32_t load_expect(input u32_t addr, input byte_type_t bt, input logic sgn);
        u32_t w;
        w = model[addr[9:2]] >> (8 * addr[1:0]);
        case (bt)
            BYTE:      return {{24{sgn & w[7]}}, w[7:0]};
            HALF_WORD: return {{16{sgn & w[15]}}, w[15:0]};
            default:   return model[addr[9:2]];
        endcase
    endfunction

    task automatic model_store(input u32_t addr, input u32_t data, input byte_type_t bt);
        int n;
        n = (bt == BYTE) ? 1 : (bt == HALF_WORD) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model[addr[9:2]][(addr[1:0] + i) * 8 +: 8] = data[i * 8 +: 8];
        end
    endtask

    // Starts at a falling edge and returns at the falling edge after acceptance
    task automatic send(input execute_memory1_pass_t p);
        while (stall_o) begin
            @(negedge clk);
        end
        pass_i = p;
        @(negedge clk);
        pass_i.valid = 1'b0;
    endtask

    task automatic push_wb(input reg_idx_t rd, input u32_t data);
        expect_t e;
        e = '0;
        e.rd   = rd;
        e.data = data;
        exp_q.push_back(e);
    endtask

    task automatic push_excp(input ecode_t code, input u32_t addr, input u32_t pc);
        expect_t e;
        e = '0;
        e.is_excp = 1'b1;
        e.ecode   = code;
        e.badv    = addr;
        e.pc      = pc;
        exp_q.push_back(e);
    endtask

    task automatic do_store(input u32_t addr, input u32_t data, input byte_type_t bt);
        send(make_op(addr, data, 1'b1, 1'b1, 1'b0, bt, 5'd0));
        model_store(addr, data, bt);
    endtask

    task automatic do_load(input u32_t addr, input byte_type_t bt, input logic sgn);
        reg_idx_t rd;
        rd = reg_idx_t'(rand_bits(4)) + 5'd1;
        push_wb(rd, load_expect(addr, bt, sgn));
        send(make_op(addr, 32'h0, 1'b1, 1'b0, sgn, bt, rd));
        // A load forwards its register but not its data
        if (!fwd_o.valid || fwd_o.idx != rd || fwd_o.data_valid) begin
            $display("ERR fwd_o valid/idx/data_valid exp 1/%h/0 got %h/%h/%h",
                     rd, fwd_o.valid, fwd_o.idx, fwd_o.data_valid);
            err_cnt++;
        end
    endtask

    task automatic drain();
        repeat (4) @(negedge clk);
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    function automatic byte_type_t rand_size();
        case (rand_bits(2) % 3)
            0:       return BYTE;
            1:       return HALF_WORD;
            default: return WORD;
        endcase
    endfunction

    function automatic u32_t aligned_addr(input u32_t base, input byte_type_t bt);
        u32_t a;
        a = base | (rand_bits(8) << 2);
        if (bt == BYTE) begin
            a = a | rand_bits(2);
        end else if (bt == HALF_WORD) begin
            a = a | (rand_bits(1) << 1);
        end
        return a;
    endfunction

    always @(negedge clk) begin
        expect_t e;
        if (rst_n) begin
            if (stall_o) begin
                stall_cnt++;
            end
            if (wb_o.valid || excp_o.valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected result from the pipeline at %0t", $time);
                    err_cnt++;
                end else begin
                    e = exp_q.pop_front();
                    if (e.is_excp != excp_o.valid) begin
                        $display("ERR excp_o.valid exp %h got %h", e.is_excp, excp_o.valid);
                        err_cnt++;
                    end else if (e.is_excp) begin
                        if (excp_o.ecode != e.ecode) begin
                            $display("ERR excp_o.ecode exp %h got %h", e.ecode, excp_o.ecode);
                            err_cnt++;
                        end
                        if (excp_o.badv != e.badv) begin
                            $display("ERR excp_o.badv exp %h got %h", e.badv, excp_o.badv);
                            err_cnt++;
                        end
                        if (excp_o.pc != e.pc) begin
                            $display("ERR excp_o.pc exp %h got %h", e.pc, excp_o.pc);
                            err_cnt++;
                        end
                    end else if (wb_o.rd != e.rd || wb_o.data != e.data) begin
                        $display("ERR wb_o rd/data exp %h/%h got %h/%h",
                                 e.rd, e.data, wb_o.rd, wb_o.data);
                        err_cnt++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the pipeline stopped responding", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int      e0;
        int      s0;
        u32_t    a;
        u32_t    d;
        byte_type_t bt;
        logic    st;
        reg_idx_t rd;
        execute_memory1_pass_t p;

        lfsr      = 32'd7;
        pc_cnt    = 32'h1c00_0000;
        err_cnt   = 0;
        stall_cnt = 0;
        rst_n     = 1'b0;
        flush_i   = 1'b0;
        pass_i    = '0;
        csr_i     = '{da: 1'b1, dmw_vseg: 3'b101, dmw_pseg: 3'b000, dmw_mat: 2'd1};
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Fill every word so later loads read known data
        for (int i = 0; i < DCACHE_WORDS; i++) begin
            do_store(i << 2, (32'h9e37_79b9 * (i + 1)) ^ (i << 20), WORD);
        end

        e0 = err_cnt;
        for (int i = 0; i < T1_OPS; i++) begin
            bt = rand_size();
            do_store(aligned_addr(32'h0, bt), rand_bits(32), bt);
            bt = rand_size();
            do_load(aligned_addr(32'h0, bt), bt, next_bit());
        end
        drain();
        report("test 1 cached store/load", e0);

        e0 = err_cnt;
        for (int i = 0; i < T2_OPS; i++) begin
            a = rand_bits(8) << 2;
            if (next_bit()) begin
                bt = HALF_WORD;
                a  = a | 32'd1 | (rand_bits(1) << 1);
            end else begin
                bt = WORD;
                a  = a | (rand_bits(1) + 32'd1);
            end
            st = next_bit();
            p  = make_op(a, rand_bits(32), 1'b1, st, 1'b0, bt, 5'd3);
            push_excp(ECODE_ALE, a, p.pc);
            send(p);
            do_load(a & ~32'd3, WORD, 1'b0);
        end
        drain();
        report("test 2 misaligned", e0);

        e0 = err_cnt;
        csr_i.da = 1'b0;
        for (int i = 0; i < T3_OPS; i++) begin
            if (next_bit()) begin
                a  = {3'b001 + 3'(rand_bits(2)), 29'h0} | (rand_bits(8) << 2);
                st = next_bit();
                p  = make_op(a, rand_bits(32), 1'b1, st, 1'b0, WORD, 5'd4);
                push_excp(st ? ECODE_PIS : ECODE_PIL, a, p.pc);
                send(p);
            end else begin
                bt = rand_size();
                a  = aligned_addr(32'ha000_0000 | (rand_bits(13) << 10), bt);
                do_store(a, rand_bits(32), bt);
                do_load(a & ~32'd3, WORD, 1'b0);
            end
        end
        drain();
        report("test 3 window mapping", e0);

        e0 = err_cnt;
        csr_i.dmw_mat = 2'd0;
        for (int i = 0; i < T4_OPS; i++) begin
            a = 32'ha000_0000 | (rand_bits(8) << 2);
            s0 = stall_cnt;
            do_store(a, rand_bits(32), WORD);
            drain();
            if (stall_cnt - s0 != UNCACHED_WAIT) begin
                $display("ERR stall_o cycles exp %h got %h", UNCACHED_WAIT, stall_cnt - s0);
                err_cnt++;
            end
            s0 = stall_cnt;
            do_load(a, rand_size(), next_bit());
            drain();
            if (stall_cnt - s0 != UNCACHED_WAIT) begin
                $display("ERR stall_o cycles exp %h got %h", UNCACHED_WAIT, stall_cnt - s0);
                err_cnt++;
            end
        end
        report("test 4 uncached", e0);

        e0 = err_cnt;
        for (int i = 0; i < T5_OPS; i++) begin
            d  = rand_bits(32);
            rd = (i % 3 == 0) ? 5'd0 : reg_idx_t'(rand_bits(5) | 32'd1);
            if (rd != 5'd0) begin
                push_wb(rd, d);
            end
            send(make_op(d, 32'h0, 1'b0, 1'b0, 1'b0, WORD, rd));
            if (fwd_o.valid != (rd != 5'd0)) begin
                $display("ERR fwd_o.valid exp %h got %h", rd != 5'd0, fwd_o.valid);
                err_cnt++;
            end else if (rd != 5'd0) begin
                if (fwd_o.idx != rd || fwd_o.data != d || !fwd_o.data_valid) begin
                    $display("ERR fwd_o idx/data/data_valid exp %h/%h/1 got %h/%h/%h",
                             rd, d, fwd_o.idx, fwd_o.data, fwd_o.data_valid);
                    err_cnt++;
                end
            end
        end
        drain();
        report("test 5 forwarding", e0);

        e0 = err_cnt;
        send(make_op(32'h1234_5678, 32'h0, 1'b0, 1'b0, 1'b0, WORD, 5'd7));
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        a = 32'ha000_0000 | (rand_bits(8) << 2);
        send(make_op(a, ~model[a[9:2]], 1'b1, 1'b1, 1'b0, WORD, 5'd0));
        if (!stall_o) begin
            $display("Uncached store did not stall before the flush");
            err_cnt++;
        end
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        drain();
        do_load(a, WORD, 1'b0);
        drain();
        report("test 6 flush", e0);

        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared", exp_q.size());
            err_cnt++;
        end
        $display("Summary: %0d errors, %0d stall cycles seen", err_cnt, stall_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* logic/mem_pipe_top.sv */
`timescale 1ns/1ps

module mem_pipe_top
    import cpu_types_pkg::*;
    import mem_pass_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_i,
    input  execute_memory1_pass_t pass_i,
    input  csr_t                  csr_i,
    output logic                  stall_o,
    output forward_req_t          fwd_o,
    output wb_t                   wb_o,
    output excp_pass_t            excp_o
);

    memory1_memory2_pass_t m1_pass;
    excp_pass_t            m1_excp;
    dcache_req_t           dc_req;
    logic                  dc_ready;
    u32_t                  dc_rdata;

    memory1_stage u_memory1_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .pass_i         (pass_i),
        .csr_i          (csr_i),
        .dcache_ready_i (dc_ready),
        .stall_o        (stall_o),
        .dc_req_o       (dc_req),
        .fwd_o          (fwd_o),
        .pass_o         (m1_pass),
        .excp_o         (m1_excp)
    );

    dcache_array u_dcache_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (dc_req),
        .ready_o (dc_ready),
        .rdata_o (dc_rdata)
    );

    memory2_stage u_memory2_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .pass_i  (m1_pass),
        .excp_i  (m1_excp),
        .rdata_i (dc_rdata),
        .wb_o    (wb_o),
        .excp_o  (excp_o)
    );

endmodule

/* logic/memory2_stage.sv */
`timescale 1ns/1ps

module memory2_stage
    import cpu_types_pkg::*;
    import mem_pass_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_i,
    input  memory1_memory2_pass_t pass_i,
    input  excp_pass_t            excp_i,
    input  u32_t                  rdata_i,
    output wb_t                   wb_o,
    output excp_pass_t            excp_o
);

    memory1_memory2_pass_t pass_r;
    excp_pass_t            excp_r;

    u32_t shifted;
    u32_t ld_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_r.valid <= 1'b0;
            excp_r.valid <= 1'b0;
        end else if (flush_i) begin
            pass_r.valid <= 1'b0;
            excp_r.valid <= 1'b0;
        end else begin
            pass_r <= pass_i;
            excp_r <= excp_i;
        end
    end

    // Move the addressed lane down to bit 0
    assign shifted = rdata_i >> {pass_r.byte_off, 3'b000};

    always_comb begin
        case (pass_r.byte_type)
            BYTE: begin
                ld_data = {{24{pass_r.is_signed & shifted[7]}}, shifted[7:0]};
            end
            HALF_WORD: begin
                ld_data = {{16{pass_r.is_signed & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                ld_data = rdata_i;
            end
        endcase
    end

    assign wb_o.valid = pass_r.valid & pass_r.is_wr_rd & (pass_r.rd != 5'd0) & ~excp_r.valid;
    assign wb_o.rd    = pass_r.rd;
    assign wb_o.data  = (pass_r.is_mem & ~pass_r.is_store) ? ld_data : pass_r.ex_out;

    assign excp_o = excp_r;

endmodule

/* logic/dcache_array.sv */
`timescale 1ns/1ps

module dcache_array
    import cpu_types_pkg::*;
    import mem_pass_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  dcache_req_t req_i,
    output logic        ready_o,
    output u32_t        rdata_o
);

    localparam int CNT_W = $clog2(UNCACHED_WAIT + 1);

    u32_t mem [DCACHE_WORDS];

    logic [CNT_W-1:0]        wait_cnt;
    logic [DCACHE_IDX_W-1:0] idx;
    logic [3:0]              byte_en;
    logic                    req_active;
    logic                    uc_active;
    logic                    done;

    assign idx        = req_i.pa[DCACHE_IDX_W+1:2];
    assign req_active = (req_i.op != DC_NOP);
    assign uc_active  = req_active & ~req_i.is_cached;

    // Uncached requests sit out the wait count before completing
    assign ready_o = ~(uc_active && (wait_cnt != CNT_W'(UNCACHED_WAIT)));
    assign done    = req_active & ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (uc_active && !ready_o) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_comb begin
        case (req_i.byte_type)
            BYTE:      byte_en = 4'b0001 << req_i.pa[1:0];
            HALF_WORD: byte_en = 4'b0011 << {req_i.pa[1], 1'b0};
            default:   byte_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (done && req_i.op == DC_W) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
        if (done && req_i.op == DC_R) begin
            rdata_o <= mem[idx];
        end
    end

    // A waiting request may only be held or withdrawn by a flush
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_active && !ready_o) |=> (req_i == $past(req_i) || req_i.op == DC_NOP)
    );

endmodule

/* logic/memory1_stage.sv */
`timescale 1ns/1ps

module memory1_stage
    import cpu_types_pkg::*;
    import mem_pass_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_i,
    input  execute_memory1_pass_t pass_i,
    input  csr_t                  csr_i,
    input  logic                  dcache_ready_i,
    output logic                  stall_o,
    output dcache_req_t           dc_req_o,
    output forward_req_t          fwd_o,
    output memory1_memory2_pass_t pass_o,
    output excp_pass_t            excp_o
);

    execute_memory1_pass_t pass_r;

    u32_t       pa;
    mat_t       mat;
    excp_pass_t trans_excp;

    logic chk_excp;
    logic eu_do;
    logic mem_req;
    logic valid_out;
    u32_t st_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_r.valid <= 1'b0;
        end else if (flush_i) begin
            pass_r.valid <= 1'b0;
        end else if (!stall_o) begin
            pass_r <= pass_i;
        end
    end

    assign chk_excp = pass_r.valid & pass_r.is_mem;

    addr_trans u_addr_trans (
        .en_i        (chk_excp),
        .va_i        (pass_r.ex_out),
        .is_store_i  (pass_r.is_store),
        .byte_type_i (pass_r.byte_type),
        .csr_i       (csr_i),
        .pa_o        (pa),
        .mat_o       (mat),
        .excp_o      (trans_excp)
    );

    assign eu_do   = pass_r.valid & ~trans_excp.valid;
    assign mem_req = eu_do & pass_r.is_mem;

    // Wait here until the cache takes the request
    assign stall_o = mem_req & ~dcache_ready_i;

    assign valid_out = pass_r.valid & ~stall_o & ~flush_i;

    // Copy the store data into every lane so the cache can pick lanes by byte enable
    always_comb begin
        case (pass_r.byte_type)
            BYTE:      st_data = {4{pass_r.rkd_data[7:0]}};
            HALF_WORD: st_data = {2{pass_r.rkd_data[15:0]}};
            default:   st_data = pass_r.rkd_data;
        endcase
    end

    always_comb begin
        dc_req_o.op        = DC_NOP;
        dc_req_o.byte_type = pass_r.byte_type;
        dc_req_o.pa        = pa;
        dc_req_o.wdata     = st_data;
        dc_req_o.is_cached = (mat == MAT_CC);
        if (mem_req && !flush_i) begin
            dc_req_o.op = pass_r.is_store ? DC_W : DC_R;
        end
    end

    // Load results are not known yet
    assign fwd_o.valid      = (pass_r.rd != 5'd0) & pass_r.is_wr_rd & eu_do;
    assign fwd_o.idx        = pass_r.rd;
    assign fwd_o.data       = pass_r.ex_out;
    assign fwd_o.data_valid = ~(pass_r.is_mem & ~pass_r.is_store);

    always_comb begin
        excp_o       = trans_excp;
        excp_o.pc    = pass_r.pc;
        excp_o.valid = trans_excp.valid & valid_out;
    end

    assign pass_o.valid     = valid_out;
    assign pass_o.pc        = pass_r.pc;
    assign pass_o.ex_out    = pass_r.ex_out;
    assign pass_o.is_mem    = pass_r.is_mem;
    assign pass_o.is_store  = pass_r.is_store;
    assign pass_o.is_signed = pass_r.is_signed;
    assign pass_o.byte_type = pass_r.byte_type;
    assign pass_o.byte_off  = pa[1:0];
    assign pass_o.is_wr_rd  = pass_r.is_wr_rd;
    assign pass_o.rd        = pass_r.rd;

    // A faulting access must never reach the cache
    a_no_req_on_excp: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dc_req_o.op != DC_NOP) |->
            !(pass_r.byte_type == HALF_WORD && pass_r.ex_out[0]) &&
            !(pass_r.byte_type == WORD && pass_r.ex_out[1:0] != 2'b00) &&
            (csr_i.da || pass_r.ex_out[31:29] == csr_i.dmw_vseg)
    );

endmodule

/* logic/addr_trans.sv */
`timescale 1ns/1ps

module addr_trans
    import cpu_types_pkg::*;
    import mem_pass_pkg::*;
(
    input  logic       en_i,
    input  u32_t       va_i,
    input  logic       is_store_i,
    input  byte_type_t byte_type_i,
    input  csr_t       csr_i,
    output u32_t       pa_o,
    output mat_t       mat_o,
    output excp_pass_t excp_o
);

    logic misalign;
    logic in_window;

    always_comb begin
        case (byte_type_i)
            HALF_WORD: misalign = va_i[0];
            WORD:      misalign = |va_i[1:0];
            default:   misalign = 1'b0;
        endcase
    end

    assign in_window = (va_i[31:29] == csr_i.dmw_vseg);

    // Direct address mode is identity mapped and always cached
    always_comb begin
        if (csr_i.da) begin
            pa_o  = va_i;
            mat_o = MAT_CC;
        end else begin
            pa_o  = {csr_i.dmw_pseg, va_i[28:0]};
            mat_o = csr_i.dmw_mat;
        end
    end

    always_comb begin
        excp_o.valid = 1'b0;
        excp_o.ecode = ECODE_ALE;
        excp_o.pc    = '0;
        excp_o.badv  = va_i;
        if (en_i) begin
            // Misalignment wins over a window miss
            if (misalign) begin
                excp_o.valid = 1'b1;
                excp_o.ecode = ECODE_ALE;
            end else if (!csr_i.da && !in_window) begin
                excp_o.valid = 1'b1;
                excp_o.ecode = is_store_i ? ECODE_PIS : ECODE_PIL;
            end
        end
    end

endmodule

/* logic/mem_pass_pkg.sv */
package mem_pass_pkg;

    import cpu_types_pkg::*;

    // Translation state read from the CSR file
    typedef struct packed {
        logic       da;
        logic [2:0] dmw_vseg;
        logic [2:0] dmw_pseg;
        mat_t       dmw_mat;
    } csr_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       ex_out;
        u32_t       rkd_data;
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_t byte_type;
        logic       is_wr_rd;
        reg_idx_t   rd;
    } execute_memory1_pass_t;

    typedef struct packed {
        logic   valid;
        ecode_t ecode;
        u32_t   pc;
        u32_t   badv;
    } excp_pass_t;

    typedef struct packed {
        dc_op_t     op;
        byte_type_t byte_type;
        u32_t       pa;
        u32_t       wdata;
        logic       is_cached;
    } dcache_req_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       ex_out;
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_t byte_type;
        logic [1:0] byte_off;
        logic       is_wr_rd;
        reg_idx_t   rd;
    } memory1_memory2_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        u32_t     data;
        logic     data_valid;
    } forward_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        u32_t     data;
    } wb_t;

endpackage

/* logic/cpu_types_pkg.sv */
package cpu_types_pkg;

    // Data and address words
    typedef logic [31:0] u32_t;

    typedef logic [4:0] reg_idx_t;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } byte_type_t;

    typedef logic [5:0] ecode_t;

    localparam ecode_t ECODE_PIL = 6'h01;
    localparam ecode_t ECODE_PIS = 6'h02;
    localparam ecode_t ECODE_ALE = 6'h09;

    // Memory access type where only the cached encoding is decoded
    typedef logic [1:0] mat_t;

    localparam mat_t MAT_CC = 2'd1;

    typedef enum logic [1:0] {
        DC_NOP = 2'd0,
        DC_R   = 2'd1,
        DC_W   = 2'd2
    } dc_op_t;

    localparam int DCACHE_WORDS = 256;
    localparam int DCACHE_IDX_W = $clog2(DCACHE_WORDS);

    // Extra cycles an uncached access holds the cache busy
    localparam int UNCACHED_WAIT = 2;

endpackage
